// ==== src.f ====
+incdir+source
source/mgmt_pkg.sv
source/mgmt_frame_buffer.sv
source/mgmt_resn_handler.sv
source/mgmt_local_cmd.sv
source/recover_req_queue.sv
source/f9mg_ctrl_top.sv
dv/f9mg_ctrl_tb.sv

// ==== dv/f9mg_ctrl_tb.sv ====
`timescale 1ns/1ns
`include "mgmt_settings.svh"

module f9mg_ctrl_tb
  import mgmt_pkg::*;
();

  typedef logic [7:0] byte_q_t [$];

  logic        clk_in;
  logic        rst_in;
  logic        pay_valid;
  logic [7:0]  pay_data;
  logic        pay_last;
  logic        rcvr_credit;
  logic        pcap_en;
  mg_sn_t      dev_sn;
  logic [31:0] mcgroup_addr;
  logic [15:0] mcgroup_port;
  logic [47:0] src_mac;
  logic [31:0] src_ip;
  logic [15:0] src_port;
  mg_sgap_t    sgap;
  logic        rcvr_valid;
  mg_rcvr_t    rcvr_data;

  // expected state kept by the reference model
  mg_ident_t   exp_ident;
  logic        exp_pcap;
  mg_sgap_t    exp_sgap;
  mg_rcvr_t    exp_q [$];

  byte_q_t     frm;
  logic [31:0] lfsr_state = 32'h6de3b294;
  int          errors;
  int          checks;
  int          tests;
  int          test_err;
  int          beat_count;

  f9mg_ctrl_top i_f9mg_ctrl_top (.*);

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  // --------------------------------------------------
  // random values and frame building
  // --------------------------------------------------
  function automatic logic lfsr_step();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 32'h80200003;
    return out;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[62:0], lfsr_step()};
    return v;
  endfunction

  function automatic mg_ident_t rand_ident(input logic [47:0] name);
    mg_ident_t r;
    r.name     = name;
    r.sn       = rand_bits(64);
    r.mc_addr  = rand_bits(32);
    r.mc_port  = rand_bits(16);
    r.src_mac  = rand_bits(48);
    r.src_ip   = rand_bits(32);
    r.src_port = rand_bits(16);
    return r;
  endfunction

  function automatic void put_str(input string s);
    for (int i = 0; i < s.len(); i++) frm.push_back(s[i]);
  endfunction

  // most significant byte goes first on the wire
  function automatic void put_val(input logic [255:0] v, input int n);
    for (int i = n - 1; i >= 0; i--) frm.push_back(v[i*8 +: 8]);
  endfunction

  function automatic void build_resn(input mg_ident_t rec);
    frm.delete();
    put_str("fonwin:resn:");
    put_val(rec, 32);
  endfunction

  function automatic void build_local(input mg_sn_t sn, input string cmd, input mg_rcvr_t arg);
    frm.delete();
    put_val(sn, 8);
    put_str(cmd);
    put_val(rand_bits(48), 6);
    put_val(arg, 4);
  endfunction

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic bit bytes_match(input byte_q_t q, input int ofs, input string s);
    bit ok;
    ok = 1'b1;
    for (int i = 0; i < s.len(); i++) begin
      if (q[ofs + i] != s[i]) ok = 1'b0;
    end
    return ok;
  endfunction

  function automatic void ref_model(input byte_q_t q);
    logic [255:0] rec;
    logic [63:0]  sn;
    logic [31:0]  arg;
    rec = '0;
    sn  = '0;
    arg = '0;
    if (q.size() == 44 && bytes_match(q, 0, "fonwin:resn:")) begin
      for (int i = 12; i < 44; i++) rec = {rec[247:0], q[i]};
      exp_ident = mg_ident_t'(rec);
      exp_pcap  = bytes_match(q, 12, "f9pcap");
    end
    if (q.size() == 22) begin
      for (int i = 0; i < 8; i++) sn = {sn[55:0], q[i]};
      for (int i = 18; i < 22; i++) arg = {arg[23:0], q[i]};
      if (sn == exp_ident.sn) begin
        if (bytes_match(q, 8, "sgap")) begin
          exp_sgap = arg;
        end else if (bytes_match(q, 8, "rcvr") && exp_q.size() < `MG_RCVR_DEPTH) begin
          exp_q.push_back(arg);
        end
      end
    end
  endfunction

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_ident(input string sig, input mg_ident_t got, input mg_ident_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic check_sgap(input string sig, input mg_sgap_t got, input mg_sgap_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic check_rcvr(input string sig, input mg_rcvr_t got, input mg_rcvr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic check_bit(input string sig, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %b expected %b", $time, sig, got, exp);
    end
  endtask

  task automatic check_outputs();
    mg_ident_t got;
    // the name has no port of its own so pcap_en stands for it
    got.name     = exp_ident.name;
    got.sn       = dev_sn;
    got.mc_addr  = mcgroup_addr;
    got.mc_port  = mcgroup_port;
    got.src_mac  = src_mac;
    got.src_ip   = src_ip;
    got.src_port = src_port;
    check_ident("ident", got, exp_ident);
    check_bit("pcap_en", pcap_en, exp_pcap);
    check_sgap("sgap", sgap, exp_sgap);
  endtask

  // every recovery beat must match the oldest pending request
  always @(posedge clk_in) begin
    if (!rst_in && rcvr_valid) begin
      beat_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected recovery beat at %0t with no request pending", $time);
      end else begin
        check_rcvr("rcvr_data", rcvr_data, exp_q.pop_front());
      end
    end
  end

  // --------------------------------------------------
  // stimulus and waits
  // --------------------------------------------------
  task automatic idle(input int n);
    repeat (n) @(posedge clk_in);
    #1;
  endtask

  task automatic send_frame(input byte_q_t q);
    ref_model(q);
    foreach (q[i]) begin
      @(posedge clk_in);
      #1;
      pay_valid = 1'b1;
      pay_data  = q[i];
      pay_last  = (i == q.size() - 1);
    end
    @(posedge clk_in);
    #1;
    pay_valid = 1'b0;
    pay_data  = '0;
    pay_last  = 1'b0;
    // results settle within four cycles of the last byte
    idle(5);
  endtask

  task automatic wait_beats(input int target, input int limit);
    int n;
    n = 0;
    while (beat_count < target && n < limit) begin
      @(posedge clk_in);
      #1;
      n++;
    end
    if (beat_count < target) begin
      errors++;
      $display("timeout at %0t: saw %0d recovery beats, wanted %0d", $time, beat_count, target);
    end
  endtask

  task automatic check_beats(input int want, input int pending);
    checks++;
    if (beat_count != want || exp_q.size() != pending) begin
      errors++;
      $display("recovery beat count is %0d with %0d pending, wanted %0d with %0d pending",
               beat_count, exp_q.size(), want, pending);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s done with %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  initial begin
    mg_ident_t rec;
    rst_in      = 1'b1;
    pay_valid   = 1'b0;
    pay_data    = '0;
    pay_last    = 1'b0;
    rcvr_credit = 1'b0;
    exp_ident   = '0;
    exp_pcap    = 1'b0;
    exp_sgap    = '0;
    repeat (5) @(posedge clk_in);
    #1;
    rst_in = 1'b0;

    idle(10);
    check_outputs();
    check_bit("rcvr_valid", rcvr_valid, 1'b0);
    end_test("reset");

    build_resn(rand_ident("f9pcap"));
    send_frame(frm);
    check_outputs();
    build_resn(rand_ident("q9scan"));
    send_frame(frm);
    check_outputs();
    end_test("reload");

    rec = rand_ident("f9pcap");
    build_resn(rec);
    void'(frm.pop_back());
    send_frame(frm);
    check_outputs();
    build_resn(rec);
    frm.push_back(8'h5a);
    send_frame(frm);
    check_outputs();
    build_resn(rec);
    frm[3] = 8'h58;
    send_frame(frm);
    check_outputs();
    build_resn(rec);
    put_val(rand_bits(48), 6);
    send_frame(frm);
    check_outputs();
    end_test("rejected");

    build_local(exp_ident.sn, "sgap", rand_bits(32));
    send_frame(frm);
    check_outputs();
    build_local(exp_ident.sn ^ 64'h1, "sgap", rand_bits(32));
    send_frame(frm);
    check_outputs();
    build_local(exp_ident.sn, "sgap", rand_bits(32));
    frm.push_back(8'h00);
    send_frame(frm);
    check_outputs();
    end_test("gap");

    for (int i = 0; i < 3; i++) begin
      build_local(exp_ident.sn, "rcvr", rand_bits(32));
      send_frame(frm);
    end
    idle(10);
    check_beats(0, 3);
    for (int k = 1; k <= 3; k++) begin
      rcvr_credit = 1'b1;
      idle(1);
      rcvr_credit = 1'b0;
      wait_beats(k, 10);
      idle(4);
      checks++;
      if (beat_count != k) begin
        errors++;
        $display("credit %0d released %0d beats in total", k, beat_count);
      end
    end
    check_beats(3, 0);
    end_test("credit");

    // two requests beyond the depth are dropped
    for (int i = 0; i < `MG_RCVR_DEPTH + 2; i++) begin
      build_local(exp_ident.sn, "rcvr", rand_bits(32));
      send_frame(frm);
    end
    rcvr_credit = 1'b1;
    idle(`MG_RCVR_DEPTH + 2);
    rcvr_credit = 1'b0;
    wait_beats(3 + `MG_RCVR_DEPTH, 40);
    idle(20);
    check_beats(3 + `MG_RCVR_DEPTH, 0);
    check_bit("rcvr_valid", rcvr_valid, 1'b0);
    end_test("overflow");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== source/f9mg_ctrl_top.sv ====
`timescale 1ns/1ns

module f9mg_ctrl_top
  import mgmt_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        pay_valid,
  input  logic [7:0]  pay_data,
  input  logic        pay_last,
  input  logic        rcvr_credit,
  output logic        pcap_en,
  output mg_sn_t      dev_sn,
  output logic [31:0] mcgroup_addr,
  output logic [15:0] mcgroup_port,
  output logic [47:0] src_mac,
  output logic [31:0] src_ip,
  output logic [15:0] src_port,
  output mg_sgap_t    sgap,
  output logic        rcvr_valid,
  output mg_rcvr_t    rcvr_data
);

  logic      frame_valid;
  mg_frame_t frame;
  mg_ident_t ident;
  logic      rcvr_push;
  mg_rcvr_t  rcvr_push_data;

  // --------------------------------------------------
  // frame assembly and command handlers
  // --------------------------------------------------
  mgmt_frame_buffer i_frame_buffer (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .pay_valid   (pay_valid),
    .pay_data    (pay_data),
    .pay_last    (pay_last),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  mgmt_resn_handler i_resn_handler (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .frame_valid (frame_valid),
    .frame       (frame),
    .ident       (ident),
    .pcap_en     (pcap_en)
  );

  mgmt_local_cmd i_local_cmd (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .frame_valid (frame_valid),
    .frame       (frame),
    .dev_sn      (ident.sn),
    .sgap        (sgap),
    .rcvr_push   (rcvr_push),
    .rcvr_data   (rcvr_push_data)
  );

  recover_req_queue i_recover_req_queue (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .push      (rcvr_push),
    .push_data (rcvr_push_data),
    .credit    (rcvr_credit),
    .out_valid (rcvr_valid),
    .out_data  (rcvr_data)
  );

  // identity record out to plain ports
  assign dev_sn       = ident.sn;
  assign mcgroup_addr = ident.mc_addr;
  assign mcgroup_port = ident.mc_port;
  assign src_mac      = ident.src_mac;
  assign src_ip       = ident.src_ip;
  assign src_port     = ident.src_port;

endmodule

// ==== source/recover_req_queue.sv ====
`timescale 1ns/1ns
`include "mgmt_settings.svh"

module recover_req_queue
  import mgmt_pkg::*;
(
  input  logic     clk_in,
  input  logic     rst_in,
  input  logic     push,
  input  mg_rcvr_t push_data,
  input  logic     credit,
  output logic     out_valid,
  output mg_rcvr_t out_data
);

  localparam int DEPTH = `MG_RCVR_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  mg_rcvr_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic [AW:0]   credits;
  logic          full;
  logic          empty;
  logic          do_push;
  logic          pop;

  assign full    = (count == (AW+1)'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;

  // one beat per cycle while entries and credits remain
  assign out_valid = !empty && (credits != '0);
  assign pop       = out_valid;
  assign out_data  = empty ? '0 : mem[rd_ptr];

  // --------------------------------------------------
  // storage and pointers
  // --------------------------------------------------
  always_ff @(posedge clk_in) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------------------
  // credit counter saturating at the queue depth
  // --------------------------------------------------
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      credits <= '0;
    end else if (credit && !pop && (credits != (AW+1)'(DEPTH))) begin
      credits <= credits + 1'b1;
    end else if (!credit && pop) begin
      credits <= credits - 1'b1;
    end
  end

  credit_sat_a: assert property (@(posedge clk_in) disable iff (rst_in)
    credits <= (AW+1)'(DEPTH));

  no_credit_a: assert property (@(posedge clk_in) disable iff (rst_in)
    (credits == '0 && !credit) |=> !out_valid);

endmodule

// ==== source/mgmt_local_cmd.sv ====
`timescale 1ns/1ns
`include "mgmt_settings.svh"

module mgmt_local_cmd
  import mgmt_pkg::*;
(
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      frame_valid,
  input  mg_frame_t frame,
  input  mg_sn_t    dev_sn,
  output mg_sgap_t  sgap,
  output logic      rcvr_push,
  output mg_rcvr_t  rcvr_data
);

  localparam int BUF_W  = `MG_BUF_LEN * 8;
  localparam int SN_W   = `MG_SN_LEN * 8;
  localparam int LCMD_W = $bits(mg_lcmd_t);
  localparam int ARG_HI = BUF_W - 1 - `MG_ARG_OFS * 8;

  logic                 st_valid;
  mg_lcmd_t             st_cmd;
  logic [`MG_LEN_W-1:0] st_len;
  mg_sgap_t             st_sgap_arg;
  mg_rcvr_t             st_rcvr_arg;
  logic                 sgap_hit;
  logic                 rcvr_hit;

  // --------------------------------------------------
  // stage 1 registers sn match, command word and argument
  // --------------------------------------------------
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      st_valid <= 1'b0;
    end else begin
      st_valid <= frame_valid && (frame.data[BUF_W-1 -: SN_W] == dev_sn);
    end
  end

  // the name bytes between command word and argument are ignored
  always_ff @(posedge clk_in) begin
    st_cmd      <= frame.data[BUF_W-1-SN_W -: LCMD_W];
    st_len      <= frame.len;
    st_sgap_arg <= frame.data[ARG_HI -: $bits(mg_sgap_t)];
    st_rcvr_arg <= frame.data[ARG_HI -: $bits(mg_rcvr_t)];
  end

  // --------------------------------------------------
  // stage 2 dispatch
  // --------------------------------------------------
  assign sgap_hit = st_valid && (st_cmd == MG_LCMD_SGAP)
                 && (st_len == `MG_LEN_W'(`MG_ARG_OFS + `MG_SGAP_LEN));
  assign rcvr_hit = st_valid && (st_cmd == MG_LCMD_RCVR)
                 && (st_len == `MG_LEN_W'(`MG_ARG_OFS + `MG_RCVR_LEN));

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      sgap      <= '0;
      rcvr_push <= 1'b0;
    end else begin
      rcvr_push <= rcvr_hit;
      if (sgap_hit) begin
        sgap <= st_sgap_arg;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rcvr_hit) begin
      rcvr_data <= st_rcvr_arg;
    end
  end

  push_vs_gap_a: assert property (@(posedge clk_in) disable iff (rst_in)
    rcvr_push |-> $stable(sgap));

endmodule

// ==== source/mgmt_resn_handler.sv ====
`timescale 1ns/1ns
`include "mgmt_settings.svh"

module mgmt_resn_handler
  import mgmt_pkg::*;
(
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      frame_valid,
  input  mg_frame_t frame,
  output mg_ident_t ident,
  output logic      pcap_en
);

  localparam int BUF_W = `MG_BUF_LEN * 8;
  localparam int CMD_W = `MG_CMD_LEN * 8;
  localparam int REC_W = `MG_REC_LEN * 8;

  logic [CMD_W-1:0] cmd_field;
  logic [REC_W-1:0] rec_field;
  logic             len_ok;
  logic             resn_hit;

  // --------------------------------------------------
  // reload frame decode
  // --------------------------------------------------
  assign cmd_field = frame.data[BUF_W-1 -: CMD_W];
  assign rec_field = frame.data[BUF_W-1-CMD_W -: REC_W];

  // the record must fill the frame exactly
  assign len_ok = (frame.len == `MG_LEN_W'(`MG_CMD_LEN + `MG_REC_LEN));

  assign resn_hit = frame_valid && len_ok && (cmd_field == MG_CMD_RESN);

  // --------------------------------------------------
  // identity record
  // --------------------------------------------------
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ident <= '0;
    end else if (resn_hit) begin
      ident <= mg_ident_t'(rec_field);
    end
  end

  // capture is enabled only for the expected device name
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pcap_en <= 1'b0;
    end else begin
      pcap_en <= (ident.name == MG_DEV_NAME);
    end
  end

endmodule

// ==== source/mgmt_frame_buffer.sv ====
`timescale 1ns/1ns
`include "mgmt_settings.svh"

module mgmt_frame_buffer
  import mgmt_pkg::*;
(
  input  logic       clk_in,
  input  logic       rst_in,
  input  logic       pay_valid,
  input  logic [7:0] pay_data,
  input  logic       pay_last,
  output logic       frame_valid,
  output mg_frame_t  frame
);

  logic [`MG_BUF_LEN*8-1:0] work_data;
  logic [`MG_BUF_LEN*8-1:0] cur_data;
  logic [`MG_BUF_LEN*8-1:0] nxt_data;
  logic [`MG_LEN_W-1:0]     wr_len;
  logic [`MG_LEN_W-1:0]     cur_len;
  logic [`MG_LEN_W-1:0]     nxt_len;
  logic                     done;

  // --------------------------------------------------
  // byte placement
  // --------------------------------------------------
  // once a frame is done the working buffer restarts empty, so a
  // byte of the next frame arriving in that cycle lands at byte 0
  always_comb begin
    cur_data = done ? '0 : work_data;
    cur_len  = done ? '0 : wr_len;
    nxt_data = cur_data;
    nxt_len  = cur_len;
    if (pay_valid) begin
      if (cur_len < `MG_BUF_LEN) begin
        nxt_data[(`MG_BUF_LEN - 1 - cur_len) * 8 +: 8] = pay_data;
      end
      // length stops at one past the buffer to flag overlong frames
      if (cur_len <= `MG_BUF_LEN) begin
        nxt_len = cur_len + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      work_data   <= '0;
      wr_len      <= '0;
      done        <= 1'b0;
      frame_valid <= 1'b0;
    end else begin
      work_data   <= nxt_data;
      wr_len      <= nxt_len;
      done        <= pay_valid && pay_last;
      frame_valid <= done;
    end
  end

  // completed frame is held until the next one
  always_ff @(posedge clk_in) begin
    if (done) begin
      frame.data <= work_data;
      frame.len  <= wr_len;
    end
  end

  frame_pulse_a: assert property (@(posedge clk_in) disable iff (rst_in)
    frame_valid |=> !frame_valid);

endmodule

// ==== source/mgmt_pkg.sv ====
`include "mgmt_settings.svh"

package mgmt_pkg;

  typedef logic [`MG_SN_LEN*8-1:0]   mg_sn_t;
  typedef logic [`MG_SGAP_LEN*8-1:0] mg_sgap_t;
  typedef logic [`MG_RCVR_LEN*8-1:0] mg_rcvr_t;

  // local command word sits between the sn and the name
  typedef logic [(`MG_CMD_LEN-`MG_SN_LEN)*8-1:0] mg_lcmd_t;

  // byte 0 of the frame is the most significant byte of data
  typedef struct packed {
    logic [`MG_BUF_LEN*8-1:0] data;
    logic [`MG_LEN_W-1:0]     len;
  } mg_frame_t;

  // identity record in the byte order of the reload frame
  typedef struct packed {
    logic [`MG_NAME_LEN*8-1:0] name;
    mg_sn_t                    sn;
    logic [31:0]               mc_addr;
    logic [15:0]               mc_port;
    logic [47:0]               src_mac;
    logic [31:0]               src_ip;
    logic [15:0]               src_port;
  } mg_ident_t;

  // --------------------------------------------------
  // command strings
  // --------------------------------------------------
  localparam logic [`MG_CMD_LEN*8-1:0]  MG_CMD_RESN  = "fonwin:resn:";
  localparam mg_lcmd_t                  MG_LCMD_SGAP = "sgap";
  localparam mg_lcmd_t                  MG_LCMD_RCVR = "rcvr";
  localparam logic [`MG_NAME_LEN*8-1:0] MG_DEV_NAME  = "f9pcap";

endpackage

// ==== source/mgmt_settings.svh ====
`ifndef MGMT_SETTINGS_SVH
`define MGMT_SETTINGS_SVH

// --------------------------------------------------
// management frame layout in bytes
// --------------------------------------------------
`define MG_CMD_LEN    12
`define MG_NAME_LEN   6
`define MG_SN_LEN     8
`define MG_BUF_LEN    48
`define MG_REC_LEN    32

// local command argument starts after sn, command word and name
`define MG_ARG_OFS    18
`define MG_SGAP_LEN   4
`define MG_RCVR_LEN   4

// frame length counter holds 0 .. MG_BUF_LEN+1
`define MG_LEN_W      6

// recovery request queue
`define MG_RCVR_DEPTH 8

`endif
